// File: src/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// word index widths of the two memories
`define IMEM_ADDR_BITS 8
`define DMEM_ADDR_BITS 8

// major opcodes
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_SYSTEM 7'b1110011

// csr number of tohost
`define CSR_TOHOST 12'h51e

`endif

// File: src/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // also carries the csr number in imm and zimm in rs1
    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_none
    } wb_sel_t;

endpackage

// File: src/sync_ram.sv
module sync_ram import rv_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 clk,
    input  logic                 wr_en,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  word_t                wr_data,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output word_t                rd_data
);

    word_t mem [0:(1 << ADDR_BITS) - 1];

    // write on the edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: src/fetch_stage.sv
`include "rv_macros.svh"

module fetch_stage import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  redirect,
    input  word_t redirect_target,
    input  logic  jal_redirect,
    input  word_t jal_target,
    output word_t next_pc,
    output word_t pc
);

    word_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    // execute redirect wins over a jal in decode
    always_comb begin
        if (reset) begin
            next_pc = `RESET_PC;
        end else if (redirect) begin
            next_pc = redirect_target;
        end else if (jal_redirect) begin
            next_pc = jal_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // pc follows the selected next pc
    always_ff @(posedge clk) begin
        pc <= next_pc;
    end

endmodule

// File: src/decode_stage.sv
`include "rv_macros.svh"

module decode_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    pc,
    input  word_t    imem_data,
    input  logic     kill,
    input  logic     rf_we,
    input  reg_idx_t rf_waddr,
    input  word_t    rf_wdata,
    output logic     jal_redirect,
    output word_t    jal_target,
    output inst_t    d_inst,
    output word_t    d_pc,
    output word_t    d_rs1_val,
    output word_t    d_rs2_val
);

    // x0 has no storage
    word_t regs [1:31];
    inst_t cur_inst;
    word_t rs1_val;
    word_t rs2_val;
    word_t imm_j;

    // wrong-path instruction behind a taken branch or jalr
    assign cur_inst = kill ? inst_t'(`NOP_INSTR) : inst_t'(imem_data);

    always_ff @(posedge clk) begin
        if (rf_we && rf_waddr != 5'd0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // async read with write-through
    always_comb begin
        if (cur_inst.r_fmt.rs1 == 5'd0) begin
            rs1_val = '0;
        end else if (rf_we && rf_waddr == cur_inst.r_fmt.rs1) begin
            rs1_val = rf_wdata;
        end else begin
            rs1_val = regs[cur_inst.r_fmt.rs1];
        end
        if (cur_inst.r_fmt.rs2 == 5'd0) begin
            rs2_val = '0;
        end else if (rf_we && rf_waddr == cur_inst.r_fmt.rs2) begin
            rs2_val = rf_wdata;
        end else begin
            rs2_val = regs[cur_inst.r_fmt.rs2];
        end
    end

    // jal resolved here, a killed jal is already a nop
    assign imm_j = {{11{cur_inst.j_fmt.imm_20}}, cur_inst.j_fmt.imm_20,
                    cur_inst.j_fmt.imm_19_12, cur_inst.j_fmt.imm_11,
                    cur_inst.j_fmt.imm_10_1, 1'b0};
    assign jal_target   = pc + imm_j;
    assign jal_redirect = (cur_inst.j_fmt.opcode == `OP_JAL);

    always_ff @(posedge clk) begin
        if (reset) begin
            d_inst <= inst_t'(`NOP_INSTR);
        end else begin
            d_inst <= cur_inst;
        end
        d_pc      <= pc;
        d_rs1_val <= rs1_val;
        d_rs2_val <= rs2_val;
    end

endmodule

// File: src/execute_writeback.sv
`include "rv_macros.svh"

module execute_writeback import rv_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  inst_t                      d_inst,
    input  word_t                      d_pc,
    input  word_t                      d_rs1_val,
    input  word_t                      d_rs2_val,
    input  word_t                      dmem_rdata,
    output logic                       redirect,
    output word_t                      redirect_target,
    output logic [`DMEM_ADDR_BITS-1:0] dmem_addr,
    output logic                       dmem_we,
    output word_t                      dmem_wdata,
    output logic                       rf_we,
    output reg_idx_t                   rf_waddr,
    output word_t                      rf_wdata,
    output word_t                      tohost
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      rs1, rs2, imm, op_a, op_b, alu_out;
    logic       use_pc, use_imm, br_eq, br_lt, br_taken, is_csr;
    alu_op_t    alu_op;
    inst_t      w_inst;
    word_t      w_alu, w_pc4;
    wb_sel_t    wb_sel;

    assign opcode = d_inst.r_fmt.opcode;
    assign funct3 = d_inst.r_fmt.funct3;

    // writeback result into either operand
    always_comb begin
        rs1 = d_rs1_val;
        rs2 = d_rs2_val;
        if (rf_we && rf_waddr != 5'd0 && rf_waddr == d_inst.r_fmt.rs1) rs1 = rf_wdata;
        if (rf_we && rf_waddr != 5'd0 && rf_waddr == d_inst.r_fmt.rs2) rs2 = rf_wdata;
    end

    // immediate, operand choice and alu op per opcode
    always_comb begin
        imm     = {{20{d_inst.i_fmt.imm[11]}}, d_inst.i_fmt.imm};
        use_pc  = 1'b0;
        use_imm = 1'b1;
        alu_op  = alu_add;
        case (opcode)
            `OP_LUI: begin
                imm    = {d_inst.u_fmt.imm_31_12, 12'b0};
                alu_op = alu_pass_b;
            end
            `OP_AUIPC: begin
                imm    = {d_inst.u_fmt.imm_31_12, 12'b0};
                use_pc = 1'b1;
            end
            `OP_BRANCH: begin
                imm = {{19{d_inst.b_fmt.imm_12}}, d_inst.b_fmt.imm_12, d_inst.b_fmt.imm_11,
                       d_inst.b_fmt.imm_10_5, d_inst.b_fmt.imm_4_1, 1'b0};
                use_pc = 1'b1;
            end
            `OP_STORE: imm = {{20{d_inst.s_fmt.imm_11_5[6]}}, d_inst.s_fmt.imm_11_5,
                              d_inst.s_fmt.imm_4_0};
            `OP_IMM, `OP_REG: begin
                use_imm = (opcode == `OP_IMM);
                case (funct3)
                    // sub only exists in the register form
                    3'b000: alu_op = (!use_imm && d_inst.r_fmt.funct7[5]) ? alu_sub : alu_add;
                    3'b001: alu_op = alu_sll;
                    3'b010: alu_op = alu_slt;
                    3'b011: alu_op = alu_sltu;
                    3'b100: alu_op = alu_xor;
                    3'b101: alu_op = d_inst.r_fmt.funct7[5] ? alu_sra : alu_srl;
                    3'b110: alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            default: ;
        endcase
    end

    assign op_a = use_pc ? d_pc : rs1;
    assign op_b = use_imm ? imm : rs2;

    always_comb begin
        case (alu_op)
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << op_b[4:0];
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> op_b[4:0];
            alu_sra:  alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            alu_pass_b: alu_out = op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    // funct3[1] selects unsigned, funct3[0] inverts
    assign br_eq    = (rs1 == rs2);
    assign br_lt    = funct3[1] ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));
    assign br_taken = funct3[2] ? (br_lt ^ funct3[0]) : (br_eq ^ funct3[0]);

    assign redirect = (opcode == `OP_JALR) || (opcode == `OP_BRANCH && br_taken);
    assign redirect_target = (opcode == `OP_JALR) ? {alu_out[31:1], 1'b0} : alu_out;

    // word access only
    assign dmem_addr  = alu_out[`DMEM_ADDR_BITS+1:2];
    assign dmem_we    = (opcode == `OP_STORE);
    assign dmem_wdata = rs2;

    // csrrw from rs1, csrrwi from zimm
    assign is_csr = (opcode == `OP_SYSTEM) && (funct3[1:0] == 2'b01)
                    && (d_inst.i_fmt.imm == `CSR_TOHOST);

    always_ff @(posedge clk) begin
        if (reset) begin
            tohost <= '0;
            w_inst <= inst_t'(`NOP_INSTR);
        end else begin
            if (is_csr) tohost <= funct3[2] ? {27'b0, d_inst.i_fmt.rs1} : rs1;
            w_inst <= d_inst;
        end
        w_alu <= alu_out;
        w_pc4 <= d_pc + 32'd4;
    end

    always_comb begin
        case (w_inst.r_fmt.opcode)
            `OP_LUI, `OP_AUIPC, `OP_IMM, `OP_REG: wb_sel = wb_alu;
            `OP_LOAD:            wb_sel = wb_mem;
            `OP_JAL, `OP_JALR:   wb_sel = wb_pc4;
            default:             wb_sel = wb_none;
        endcase
    end

    assign rf_waddr = w_inst.r_fmt.rd;
    assign rf_we    = (wb_sel != wb_none) && (rf_waddr != 5'd0);

    // load data arrives straight from the memory in this cycle
    always_comb begin
        case (wb_sel)
            wb_mem:  rf_wdata = dmem_rdata;
            wb_pc4:  rf_wdata = w_pc4;
            default: rf_wdata = w_alu;
        endcase
    end

endmodule

// File: src/rv_core.sv
`include "rv_macros.svh"

module rv_core import rv_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       imem_load_en,
    input  logic [`IMEM_ADDR_BITS-1:0] imem_load_addr,
    input  word_t                      imem_load_data,
    output word_t                      tohost
);

    word_t    next_pc, pc, imem_data;
    logic     redirect, jal_redirect;
    word_t    redirect_target, jal_target;
    inst_t    d_inst;
    word_t    d_pc, d_rs1_val, d_rs2_val;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;
    logic     dmem_we;
    logic [`DMEM_ADDR_BITS-1:0] dmem_addr;
    word_t    dmem_wdata, dmem_rdata;

    fetch_stage fetch (
        .clk(clk), .reset(reset),
        .redirect(redirect), .redirect_target(redirect_target),
        .jal_redirect(jal_redirect), .jal_target(jal_target),
        .next_pc(next_pc), .pc(pc)
    );

    // program is written only through the load port
    sync_ram #(.ADDR_BITS(`IMEM_ADDR_BITS)) imem (
        .clk(clk),
        .wr_en(imem_load_en), .wr_addr(imem_load_addr), .wr_data(imem_load_data),
        .rd_addr(next_pc[`IMEM_ADDR_BITS+1:2]), .rd_data(imem_data)
    );

    decode_stage decode (
        .clk(clk), .reset(reset),
        .pc(pc), .imem_data(imem_data), .kill(redirect),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .jal_redirect(jal_redirect), .jal_target(jal_target),
        .d_inst(d_inst), .d_pc(d_pc), .d_rs1_val(d_rs1_val), .d_rs2_val(d_rs2_val)
    );

    execute_writeback execute (
        .clk(clk), .reset(reset),
        .d_inst(d_inst), .d_pc(d_pc), .d_rs1_val(d_rs1_val), .d_rs2_val(d_rs2_val),
        .dmem_rdata(dmem_rdata),
        .redirect(redirect), .redirect_target(redirect_target),
        .dmem_addr(dmem_addr), .dmem_we(dmem_we), .dmem_wdata(dmem_wdata),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .tohost(tohost)
    );

    // one address for read and write
    sync_ram #(.ADDR_BITS(`DMEM_ADDR_BITS)) dmem (
        .clk(clk),
        .wr_en(dmem_we), .wr_addr(dmem_addr), .wr_data(dmem_wdata),
        .rd_addr(dmem_addr), .rd_data(dmem_rdata)
    );

endmodule

// File: tests/rv_core_tb.sv
`include "rv_macros.svh"

module rv_core_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 120;
    localparam int CLK_PERIOD      = 4;
    localparam int RUN_CYCLES      = 100;
    localparam int POISON          = 'h123;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       imem_load_en;
    logic [`IMEM_ADDR_BITS-1:0] imem_load_addr;
    word_t                      imem_load_data;
    word_t                      tohost;

    int    seed = 32'h95b7_90cb;
    inst_t prog[$];
    word_t host_seen[$];
    word_t host_prev;
    // funct3 of add, sub, sll, slt, sltu, xor, srl, sra, or, and
    int    op_funct3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};

    rv_core DUT (
        .clk(clk),
        .reset(reset),
        .imem_load_en(imem_load_en),
        .imem_load_addr(imem_load_addr),
        .imem_load_data(imem_load_data),
        .tohost(tohost)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // record each new tohost value on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            host_prev = '0;
        end else if (tohost != host_prev) begin
            host_seen.push_back(tohost);
            host_prev = tohost;
        end
    end

    function automatic inst_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        inst_t x;
        x.r_fmt.funct7 = f7[6:0];
        x.r_fmt.rs2    = rs2[4:0];
        x.r_fmt.rs1    = rs1[4:0];
        x.r_fmt.funct3 = f3[2:0];
        x.r_fmt.rd     = rd[4:0];
        x.r_fmt.opcode = `OP_REG;
        return x;
    endfunction

    function automatic inst_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] op);
        inst_t x;
        x.i_fmt.imm    = imm[11:0];
        x.i_fmt.rs1    = rs1[4:0];
        x.i_fmt.funct3 = f3[2:0];
        x.i_fmt.rd     = rd[4:0];
        x.i_fmt.opcode = op;
        return x;
    endfunction

    // sw only
    function automatic inst_t s_type(int imm, int rs2, int rs1);
        inst_t x;
        x.s_fmt.imm_11_5 = imm[11:5];
        x.s_fmt.rs2      = rs2[4:0];
        x.s_fmt.rs1      = rs1[4:0];
        x.s_fmt.funct3   = 3'b010;
        x.s_fmt.imm_4_0  = imm[4:0];
        x.s_fmt.opcode   = `OP_STORE;
        return x;
    endfunction

    function automatic inst_t b_type(int off, int rs2, int rs1, int f3);
        inst_t x;
        x.b_fmt.imm_12   = off[12];
        x.b_fmt.imm_10_5 = off[10:5];
        x.b_fmt.rs2      = rs2[4:0];
        x.b_fmt.rs1      = rs1[4:0];
        x.b_fmt.funct3   = f3[2:0];
        x.b_fmt.imm_4_1  = off[4:1];
        x.b_fmt.imm_11   = off[11];
        x.b_fmt.opcode   = `OP_BRANCH;
        return x;
    endfunction

    function automatic inst_t u_type(int upper, int rd, logic [6:0] op);
        inst_t x;
        x.u_fmt.imm_31_12 = upper[19:0];
        x.u_fmt.rd        = rd[4:0];
        x.u_fmt.opcode    = op;
        return x;
    endfunction

    function automatic inst_t j_type(int off, int rd);
        inst_t x;
        x.j_fmt.imm_20    = off[20];
        x.j_fmt.imm_10_1  = off[10:1];
        x.j_fmt.imm_11    = off[11];
        x.j_fmt.imm_19_12 = off[19:12];
        x.j_fmt.rd        = rd[4:0];
        x.j_fmt.opcode    = `OP_JAL;
        return x;
    endfunction

    function automatic inst_t csrrw(int src);
        inst_t x;
        x = i_type(0, src, 1, 0, `OP_SYSTEM);
        x.i_fmt.imm = `CSR_TOHOST;
        return x;
    endfunction

    // zimm sits in the rs1 field
    function automatic inst_t csrrwi(int zimm);
        inst_t x;
        x = i_type(0, zimm, 5, 0, `OP_SYSTEM);
        x.i_fmt.imm = `CSR_TOHOST;
        return x;
    endfunction

    function automatic word_t isa_result(int k, word_t a, word_t b);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a << b[4:0];
            3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4: return (a < b) ? 32'd1 : 32'd0;
            5: return a ^ b;
            6: return a >> b[4:0];
            7: return word_t'($signed(a) >>> b[4:0]);
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(inst_t x);
        prog.push_back(x);
    endtask

    // lui plus addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_constant(int rd, word_t value);
        word_t upper;
        upper = (value + 32'h800) >> 12;
        emit(u_type(int'(upper), rd, `OP_LUI));
        emit(i_type(int'(value), rd, 0, rd, `OP_IMM));
    endtask

    task automatic load_program();
        logic [`IMEM_ADDR_BITS-1:0] addr;
        addr = '0;
        reset = 1'b1;
        host_seen.delete();
        foreach (prog[i]) begin
            imem_load_en   = 1'b1;
            imem_load_addr = addr;
            imem_load_data = prog[i];
            @(negedge clk);
            addr = addr + 1'b1;
        end
        imem_load_en = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    // release reset and let the program reach its self-loop
    task automatic run_program();
        reset = 1'b0;
        repeat (RUN_CYCLES) @(negedge clk);
    endtask

    task automatic compare_word(word_t expected, word_t actual, string what);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s expected %h, got %h",
                     $time, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "%s does not match", what);
        end
    endtask

    task automatic compare_count(int expected, int actual, string what);
        if (actual != expected) begin
            $display("MISMATCH at time %0t: %s expected %0d, got %0d",
                     $time, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "%s does not match", what);
        end
    endtask

    task automatic reset_value_test();
        prog.delete();
        emit(j_type(0, 0));
        load_program();
        compare_word('0, tohost, "tohost right after reset");
        run_program();
        compare_word('0, tohost, "tohost with no csr write");
        compare_count(0, host_seen.size(), "tohost writes without csr");
    endtask

    task automatic arithmetic_test();
        word_t a, b, fold;
        a = $random(seed);
        b = $random(seed);
        fold = '0;
        prog.delete();
        load_constant(1, a);
        load_constant(2, b);
        emit(i_type(0, 0, 0, 4, `OP_IMM));
        for (int k = 0; k < 10; k++) begin
            emit(r_type((k == 1 || k == 7) ? 32 : 0, 2, 1, op_funct3[k], 3));
            emit(r_type(0, 3, 4, 4, 4));
            fold = fold ^ isa_result(k, a, b);
        end
        emit(csrrw(4));
        emit(j_type(0, 0));
        load_program();
        run_program();
        compare_word(fold, tohost, "xor fold of alu results");
    endtask

    task automatic forwarding_test();
        word_t r0, r1, e7, e8;
        r0 = $random(seed);
        r1 = $random(seed);
        prog.delete();
        load_constant(5, r0);
        load_constant(6, r1);
        emit(r_type(0, 6, 5, 0, 7));
        emit(r_type(0, 6, 7, 0, 7));
        emit(r_type(0, 5, 7, 0, 8));
        emit(r_type(0, 7, 8, 0, 8));
        emit(csrrw(8));
        emit(j_type(0, 0));
        e7 = r0 + r1;
        e7 = e7 + r1;
        e8 = e7 + r0;
        e8 = e8 + e7;
        load_program();
        run_program();
        compare_word(e8, tohost, "dependent add chain");
    endtask

    task automatic jump_test();
        int    k, c;
        word_t link1, link2, target;
        k = $random(seed) & 1023;
        c = $random(seed) & 1023;
        prog.delete();
        emit(i_type(k, 0, 0, 10, `OP_IMM));
        link1 = 4 * prog.size() + 4;
        emit(j_type(12, 1));
        emit(i_type(POISON, 10, 0, 10, `OP_IMM));
        emit(i_type(POISON, 10, 0, 10, `OP_IMM));
        emit(r_type(0, 1, 10, 0, 10));
        // jalr lands four words past the addi that sets its base
        target = 4 * (prog.size() + 4);
        emit(i_type(int'(target), 0, 0, 2, `OP_IMM));
        link2 = 4 * prog.size() + 4;
        emit(i_type(0, 2, 0, 3, `OP_JALR));
        emit(i_type(POISON, 10, 0, 10, `OP_IMM));
        emit(i_type(POISON, 10, 0, 10, `OP_IMM));
        emit(r_type(0, 3, 10, 0, 10));
        emit(i_type(c, 10, 0, 10, `OP_IMM));
        emit(csrrw(10));
        emit(j_type(0, 0));
        load_program();
        run_program();
        compare_word(word_t'(k + c) + link1 + link2, tohost, "links plus constants");
    endtask

    task automatic branch_test();
        int n;
        n = ($random(seed) & 7) + 1;
        prog.delete();
        emit(i_type(0, 0, 0, 11, `OP_IMM));
        emit(i_type(1, 0, 0, 12, `OP_IMM));
        emit(i_type(n + 1, 0, 0, 13, `OP_IMM));
        // loop body at word 3
        emit(r_type(0, 12, 11, 0, 11));
        emit(i_type(1, 12, 0, 12, `OP_IMM));
        emit(b_type(-8, 13, 12, 1));
        emit(i_type(-1, 0, 0, 14, `OP_IMM));
        emit(b_type(8, 0, 14, 4));
        emit(i_type(POISON, 11, 0, 11, `OP_IMM));
        // 0 >= all ones is false unsigned
        emit(b_type(12, 14, 0, 7));
        emit(csrrw(11));
        emit(j_type(0, 0));
        emit(i_type(POISON, 11, 0, 11, `OP_IMM));
        emit(csrrw(11));
        emit(j_type(0, 0));
        load_program();
        run_program();
        compare_word(word_t'(n * (n + 1) / 2), tohost, "loop sum");
    endtask

    task automatic memory_test();
        word_t w0, w1, sum, zimm;
        w0 = $random(seed);
        w1 = $random(seed);
        if (w0 + w1 == '0) begin
            w1 = w1 + 1;
        end
        sum = w0 + w1;
        zimm = $random(seed) & 31;
        if (zimm == sum) begin
            zimm = zimm ^ 1;
        end
        prog.delete();
        load_constant(1, w0);
        load_constant(2, w1);
        emit(i_type(64, 0, 0, 3, `OP_IMM));
        emit(s_type(0, 1, 3));
        emit(s_type(4, 2, 3));
        emit(i_type(0, 3, 2, 4, `OP_LOAD));
        emit(i_type(4, 3, 2, 5, `OP_LOAD));
        emit(r_type(0, 5, 4, 0, 6));
        emit(csrrw(6));
        emit(csrrwi(int'(zimm)));
        emit(j_type(0, 0));
        load_program();
        run_program();
        compare_count(2, host_seen.size(), "tohost write count");
        compare_word(sum, host_seen[0], "sum of loaded words");
        compare_word(zimm, host_seen[1], "csrrwi immediate");
    endtask

    initial begin
        reset          = 1'b1;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        // tohost is left nonzero here, so the reset check below sees it cleared
        arithmetic_test();
        reset_value_test();
        forwarding_test();
        jump_test();
        branch_test();
        memory_test();
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
        $display("ERRORS FOUND");
        $fatal(1, "timeout: the tests did not finish within the time limit");
    end

endmodule

// File: vlog.f
+incdir+src
src/rv_pkg.sv
src/sync_ram.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_writeback.sv
src/rv_core.sv
tests/rv_core_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --timescale 1ns/100ps --top-module rv_core_tb -f vlog.f \
    -o rv_core_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
    || echo "simulation passed"
